// File: design/arcade_pkg.sv
/* Arcade front end shared definitions */

package arcade_pkg;

	// ====================
	// Game variants
	// ====================

	// Download codes of the variant byte
	typedef enum logic [7:0] {
		variant_orig  = 8'd0,
		variant_plus  = 8'd1,
		variant_club  = 8'd2,
		variant_bird  = 8'd4,
		variant_ms    = 8'd5,
		variant_gork  = 8'd6,
		variant_mrtnt = 8'd7,
		variant_woodp = 8'd8,
		variant_eeek  = 8'd9,
		variant_alib  = 8'd10,
		variant_ponp  = 8'd11,
		variant_van   = 8'd12,
		variant_pmm   = 8'd13,
		variant_dshop = 8'd14,
		variant_glob  = 8'd15,
		variant_jmpst = 8'd16,
		// Any code not listed above
		variant_other = 8'hFF
	} variant_t;

	// Loader download indices
	localparam logic [7:0] dl_index_variant = 8'd1;
	localparam logic [7:0] dl_index_dip     = 8'd254;

	// ====================
	// Pad word layout
	// ====================

	localparam int joy_right  = 0;
	localparam int joy_left   = 1;
	localparam int joy_down   = 2;
	localparam int joy_up     = 3;
	localparam int joy_fire   = 4;
	localparam int joy_start1 = 5;
	localparam int joy_start2 = 6;
	localparam int joy_coin   = 7;
	localparam int joy_cheat  = 8;
	localparam int joy_pause  = 9;

	// Serial adapter button word layout
	localparam int ll_fire   = 0;
	localparam int ll_coin   = 4;
	localparam int ll_start1 = 5;
	localparam int ll_start2 = 6;
	localparam int ll_right  = 24;
	localparam int ll_left   = 25;
	localparam int ll_down   = 26;
	localparam int ll_up     = 27;

	// DIP bytes before any download, all switches open
	localparam logic [7:0] dip_reset_value = 8'hFF;

endpackage

// File: design/clock_enables.sv
/* Clock enable generator */

module clock_enables #(
	parameter int DIV_6M   = 4,
	parameter int DIV_4M   = 6,
	parameter int DIV_1M79 = 13
) (
	input  logic clk_sys,
	input  logic reset,
	output logic ce_6m,
	output logic ce_4m,
	output logic ce_1m79
);

	// ====================
	// Modulo counters
	// ====================

	// One counter per divisor, index 0 is the fastest
	for (genvar i = 0; i < 3; i++) begin : g_div
		localparam int DIV = (i == 0) ? DIV_6M : (i == 1) ? DIV_4M : DIV_1M79;
		localparam int CW  = (DIV > 1) ? $clog2(DIV) : 1;

		logic [CW-1:0] cnt;
		logic          ce_q;

		always_ff @(posedge clk_sys) begin
			if (reset) begin
				cnt  <= '0;
				ce_q <= 1'b0;
			end else begin
				// Pulse once per wrap of the counter
				ce_q <= (cnt == '0);
				if (cnt == CW'(DIV - 1))
					cnt <= '0;
				else
					cnt <= cnt + 1'b1;
			end
		end
	end

	// Registered pulses out
	assign ce_6m   = g_div[0].ce_q;
	assign ce_4m   = g_div[1].ce_q;
	assign ce_1m79 = g_div[2].ce_q;

endmodule

// File: design/rom_config_capture.sv
/* ROM configuration capture */

module rom_config_capture (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  logic                 dl_wr,
	input  logic [7:0]           dl_index,
	input  logic [24:0]          dl_addr,
	input  logic [7:0]           dl_data,
	output arcade_pkg::variant_t game_variant,
	output logic [7:0]           dip_0,
	output logic [7:0]           dip_1,
	output logic [7:0]           dip_2,
	output logic [7:0]           dip_3
);

	logic [7:0] variant_raw;
	logic [7:0] dip_bank [4];
	logic       variant_wr;
	logic       dip_wr;

	// Write qualifiers
	assign variant_wr = dl_wr && (dl_index == arcade_pkg::dl_index_variant);
	// DIP bytes live at addresses 0 to 3 only
	assign dip_wr = dl_wr && (dl_index == arcade_pkg::dl_index_dip) && (dl_addr[24:2] == '0);

	// ====================
	// Variant byte
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			variant_raw <= 8'd0;
		end else if (variant_wr) begin
			variant_raw <= dl_data;
		end
	end

	// Decode one edge behind the raw byte
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			game_variant <= arcade_pkg::variant_orig;
		end else if (variant_raw == 8'd3 || variant_raw > 8'd16) begin
			// Code 3 and anything past the last entry are unknown
			game_variant <= arcade_pkg::variant_other;
		end else begin
			game_variant <= arcade_pkg::variant_t'(variant_raw);
		end
	end

	// ====================
	// DIP bank
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < 4; i++)
				dip_bank[i] <= arcade_pkg::dip_reset_value;
		end else if (dip_wr) begin
			dip_bank[dl_addr[1:0]] <= dl_data;
		end
	end

	assign dip_0 = dip_bank[0];
	assign dip_1 = dip_bank[1];
	assign dip_2 = dip_bank[2];
	assign dip_3 = dip_bank[3];

endmodule

// File: design/pad_merge.sv
/* Controller merge */

module pad_merge (
	input  arcade_pkg::variant_t game_variant,
	input  logic [15:0]          usb_joy_0,
	input  logic [15:0]          usb_joy_1,
	input  logic [31:0]          ll_buttons_0,
	input  logic [31:0]          ll_buttons_1,
	output logic [15:0]          pad_1,
	output logic [15:0]          pad_2,
	output logic                 osd_button
);

	logic [15:0] ll_pad_0;
	logic [15:0] ll_pad_1;
	logic [15:0] pad_all;
	logic        split_pads;

	// Adapter word into pad layout, upper bits stay zero
	function automatic logic [15:0] to_pad(input logic [31:0] b);
		logic [15:0] p;
		p = '0;
		p[arcade_pkg::joy_right]  = b[arcade_pkg::ll_right];
		p[arcade_pkg::joy_left]   = b[arcade_pkg::ll_left];
		p[arcade_pkg::joy_down]   = b[arcade_pkg::ll_down];
		p[arcade_pkg::joy_up]     = b[arcade_pkg::ll_up];
		p[arcade_pkg::joy_fire]   = b[arcade_pkg::ll_fire];
		p[arcade_pkg::joy_start1] = b[arcade_pkg::ll_start1];
		p[arcade_pkg::joy_start2] = b[arcade_pkg::ll_start2];
		p[arcade_pkg::joy_coin]   = b[arcade_pkg::ll_coin];
		return p;
	endfunction

	assign ll_pad_0 = to_pad(ll_buttons_0);
	assign ll_pad_1 = to_pad(ll_buttons_1);

	// Two-player games keep adapter pads apart
	assign split_pads = (game_variant == arcade_pkg::variant_club) ||
		(game_variant == arcade_pkg::variant_jmpst);
	assign pad_all = usb_joy_0 | usb_joy_1 | ll_pad_0 | ll_pad_1;

	assign pad_1 = split_pads ? ll_pad_0 : pad_all;
	assign pad_2 = split_pads ? ll_pad_1 : pad_all;

	// Down + start1 + fire on either adapter opens the OSD
	assign osd_button =
		(ll_buttons_0[arcade_pkg::ll_down] && ll_buttons_0[arcade_pkg::ll_start1] &&
		ll_buttons_0[arcade_pkg::ll_fire]) ||
		(ll_buttons_1[arcade_pkg::ll_down] && ll_buttons_1[arcade_pkg::ll_start1] &&
		ll_buttons_1[arcade_pkg::ll_fire]);

endmodule

// File: design/one_dir_filter.sv
/* Single direction joystick filter */

module one_dir_filter (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  arcade_pkg::variant_t game_variant,
	input  logic [3:0]           pad_dirs,
	output logic [3:0]           dirs
);

	logic [3:0] dirs_q1;
	logic [3:0] dirs_q2;
	logic [3:0] mask;
	logic [3:0] dirs_new;
	logic       filter_off;

	// Rising edges between the two samples
	assign dirs_new   = dirs_q1 & ~dirs_q2;
	// Bird plays with diagonals
	assign filter_off = (game_variant == arcade_pkg::variant_bird);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dirs_q1 <= '0;
			dirs_q2 <= '0;
			mask    <= '1;
		end else begin
			dirs_q1 <= pad_dirs;
			dirs_q2 <= dirs_q1;
			// Reopen once the kept direction is let go
			if (!(|(pad_dirs & mask)) || filter_off)
				mask <= '1;
			else if (dirs_new[3])
				mask <= 4'b1000;
			else if (dirs_new[2])
				mask <= 4'b0100;
			else if (dirs_new[1])
				mask <= 4'b0010;
			else if (dirs_new[0])
				mask <= 4'b0001;
		end
	end

	assign dirs = dirs_q1 & mask;

endmodule

// File: design/input_port_map.sv
/* Game input port builder */

module input_port_map (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  arcade_pkg::variant_t game_variant,
	input  logic [15:0]          pad_1,
	input  logic [15:0]          pad_2,
	input  logic [3:0]           dir_1,
	input  logic [3:0]           dir_2,
	input  logic [7:0]           dip_0,
	input  logic [7:0]           dip_1,
	input  logic [7:0]           dip_2,
	input  logic [7:0]           dip_3,
	output logic [7:0]           in0,
	output logic [7:0]           in1,
	output logic [7:0]           dipsw1,
	output logic [7:0]           dipsw2
);

	// Variant flags
	logic is_orig, is_plus, is_bird, is_ms, is_woodp, is_eeek, is_alib;
	logic is_ponp, is_pmm, is_jmpst, is_gm, is_ponp_fam, cheat_ok;

	// Buttons shared across players
	logic coin, start1, start2, cheat, fire, fire2;
	logic [7:0] in0_raw;
	logic [7:0] in1_raw;

	assign is_orig  = (game_variant == arcade_pkg::variant_orig);
	assign is_plus  = (game_variant == arcade_pkg::variant_plus);
	assign is_bird  = (game_variant == arcade_pkg::variant_bird);
	assign is_ms    = (game_variant == arcade_pkg::variant_ms);
	assign is_woodp = (game_variant == arcade_pkg::variant_woodp);
	assign is_eeek  = (game_variant == arcade_pkg::variant_eeek);
	assign is_alib  = (game_variant == arcade_pkg::variant_alib);
	assign is_ponp  = (game_variant == arcade_pkg::variant_ponp);
	assign is_pmm   = (game_variant == arcade_pkg::variant_pmm);
	assign is_jmpst = (game_variant == arcade_pkg::variant_jmpst);
	assign is_gm    = (game_variant == arcade_pkg::variant_gork) ||
		(game_variant == arcade_pkg::variant_mrtnt);
	// Ponp hardware family
	assign is_ponp_fam = is_ponp || (game_variant == arcade_pkg::variant_van) ||
		(game_variant == arcade_pkg::variant_dshop);
	// Games with a cheat input on in0 bit 4
	assign cheat_ok = is_orig || is_plus || is_ms || is_bird || is_alib || is_woodp;

	assign coin   = pad_1[arcade_pkg::joy_coin] | pad_2[arcade_pkg::joy_coin];
	assign start1 = pad_1[arcade_pkg::joy_start1] | pad_2[arcade_pkg::joy_start1];
	assign start2 = pad_1[arcade_pkg::joy_start2] | pad_2[arcade_pkg::joy_start2];
	assign cheat  = pad_1[arcade_pkg::joy_cheat] | pad_2[arcade_pkg::joy_cheat];
	assign fire   = pad_1[arcade_pkg::joy_fire];
	assign fire2  = pad_2[arcade_pkg::joy_fire];

	// ====================
	// Active high port bytes
	// ====================

	assign in0_raw = {
		is_eeek & fire2,
		is_alib & fire,
		coin,
		(cheat_ok & cheat) | (is_ponp_fam & fire),
		dir_1[arcade_pkg::joy_down],
		dir_1[arcade_pkg::joy_right],
		dir_1[arcade_pkg::joy_left],
		dir_1[arcade_pkg::joy_up]
	};

	// Pmm steals player 2 right for fire
	assign in1_raw = {
		is_gm & fire2,
		start2 | (is_eeek & fire) | (is_jmpst & fire2),
		start1 | (is_jmpst & fire),
		(is_gm & fire) | ((is_alib | is_ponp_fam) & fire2),
		~is_pmm & dir_2[arcade_pkg::joy_down],
		is_pmm ? fire : dir_2[arcade_pkg::joy_right],
		~is_pmm & dir_2[arcade_pkg::joy_left],
		~is_pmm & dir_2[arcade_pkg::joy_up]
	};

	// Polarity fix then DIP mask, one register stage
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			in0    <= 8'hFF;
			in1    <= 8'hFF;
			dipsw1 <= arcade_pkg::dip_reset_value;
			dipsw2 <= 8'hFF;
		end else begin
			in0    <= dip_0 & ((is_ponp ? 8'hE0 : 8'hFF) ^ in0_raw);
			in1    <= dip_1 & ((is_ponp ? 8'h00 : 8'hFF) ^ in1_raw);
			dipsw1 <= dip_2;
			dipsw2 <= is_ponp_fam ? dip_3 : 8'hFF;
		end
	end

endmodule

// File: design/arcade_ctrl_top.sv
/* Arcade control front end */

module arcade_ctrl_top #(
	parameter int DIV_6M   = 4,
	parameter int DIV_4M   = 6,
	parameter int DIV_1M79 = 13
) (
	input  logic                 clk_sys,
	input  logic                 reset,
	// Loader download port
	input  logic                 dl_wr,
	input  logic [7:0]           dl_index,
	input  logic [24:0]          dl_addr,
	input  logic [7:0]           dl_data,
	// Controllers
	input  logic [15:0]          usb_joy_0,
	input  logic [15:0]          usb_joy_1,
	input  logic [31:0]          ll_buttons_0,
	input  logic [31:0]          ll_buttons_1,
	output logic                 ce_6m,
	output logic                 ce_4m,
	output logic                 ce_1m79,
	output arcade_pkg::variant_t game_variant,
	// Game ports
	output logic [7:0]           in0,
	output logic [7:0]           in1,
	output logic [7:0]           dipsw1,
	output logic [7:0]           dipsw2,
	output logic                 osd_button
);

	logic [7:0]  dip_0;
	logic [7:0]  dip_1;
	logic [7:0]  dip_2;
	logic [7:0]  dip_3;
	logic [15:0] pad_1;
	logic [15:0] pad_2;
	logic [3:0]  dir_1;
	logic [3:0]  dir_2;

	// ====================
	// Timing
	// ====================

	clock_enables #(
		.DIV_6M   (DIV_6M),
		.DIV_4M   (DIV_4M),
		.DIV_1M79 (DIV_1M79)
	) u_clock_enables (
		.clk_sys (clk_sys),
		.reset   (reset),
		.ce_6m   (ce_6m),
		.ce_4m   (ce_4m),
		.ce_1m79 (ce_1m79)
	);

	// Variant and DIP bytes from the loader
	rom_config_capture u_rom_config_capture (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_wr        (dl_wr),
		.dl_index     (dl_index),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.game_variant (game_variant),
		.dip_0        (dip_0),
		.dip_1        (dip_1),
		.dip_2        (dip_2),
		.dip_3        (dip_3)
	);

	// ====================
	// Player inputs
	// ====================

	pad_merge u_pad_merge (
		.game_variant (game_variant),
		.usb_joy_0    (usb_joy_0),
		.usb_joy_1    (usb_joy_1),
		.ll_buttons_0 (ll_buttons_0),
		.ll_buttons_1 (ll_buttons_1),
		.pad_1        (pad_1),
		.pad_2        (pad_2),
		.osd_button   (osd_button)
	);

	// Direction bits sit at the bottom of the pad word
	one_dir_filter filter_1 (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.game_variant (game_variant),
		.pad_dirs     (pad_1[3:0]),
		.dirs         (dir_1)
	);

	one_dir_filter filter_2 (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.game_variant (game_variant),
		.pad_dirs     (pad_2[3:0]),
		.dirs         (dir_2)
	);

	input_port_map u_input_port_map (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.game_variant (game_variant),
		.pad_1        (pad_1),
		.pad_2        (pad_2),
		.dir_1        (dir_1),
		.dir_2        (dir_2),
		.dip_0        (dip_0),
		.dip_1        (dip_1),
		.dip_2        (dip_2),
		.dip_3        (dip_3),
		.in0          (in0),
		.in1          (in1),
		.dipsw1       (dipsw1),
		.dipsw2       (dipsw2)
	);

endmodule

// File: test/arcade_ctrl_properties.sv
/* Front end assertions */

module arcade_ctrl_properties (
	input logic                 clk_sys,
	input logic                 reset,
	input logic                 ce_6m,
	input logic                 ce_4m,
	input logic                 ce_1m79,
	input arcade_pkg::variant_t game_variant,
	input logic [7:0]           dipsw2
);

	logic ponp_fam;

	// Ponp hardware family, the only users of dipsw2
	assign ponp_fam = (game_variant == arcade_pkg::variant_ponp) ||
		(game_variant == arcade_pkg::variant_van) ||
		(game_variant == arcade_pkg::variant_dshop);

	// ====================
	// Enable pulses
	// ====================

	ce_6m_single: assert property (@(posedge clk_sys) disable iff (reset) ce_6m |=> !ce_6m)
		else $error("ce_6m high for two cycles in a row");
	ce_4m_single: assert property (@(posedge clk_sys) disable iff (reset) ce_4m |=> !ce_4m)
		else $error("ce_4m high for two cycles in a row");
	ce_1m79_single: assert property (@(posedge clk_sys) disable iff (reset) ce_1m79 |=> !ce_1m79)
		else $error("ce_1m79 high for two cycles in a row");

	// Quiet once reset has been seen on an edge
	ce_quiet_in_reset: assert property (@(posedge clk_sys)
		reset && $past(reset) |-> !(ce_6m || ce_4m || ce_1m79))
		else $error("clock enable high while reset is held");

	// Port register lags the variant by one edge
	dipsw2_fixed: assert property (@(posedge clk_sys) disable iff (reset)
		!$past(ponp_fam) |-> dipsw2 == 8'hFF)
		else $error("dipsw2 not FF outside the ponp family");

endmodule

bind arcade_ctrl_top arcade_ctrl_properties u_properties (
	.clk_sys      (clk_sys),
	.reset        (reset),
	.ce_6m        (ce_6m),
	.ce_4m        (ce_4m),
	.ce_1m79      (ce_1m79),
	.game_variant (game_variant),
	.dipsw2       (dipsw2)
);

// File: test/tb_arcade_ctrl.sv
/* Arcade front end testbench */

module tb_arcade_ctrl;

	localparam int clk_period   = 10;
	localparam int reset_cycles = 16;
	localparam int div_6m       = 4;
	localparam int div_4m       = 6;
	localparam int div_1m79     = 13;
	// Rough length of each test in cycles
	localparam int enable_cycles   = 3 * 4 * div_1m79;
	localparam int download_cycles = 40;
	localparam int button_cycles   = 9 * 40;
	localparam int filter_cycles   = 40;
	localparam int split_cycles    = 40;
	localparam int margin_cycles   = 200;
	localparam int run_cycles = reset_cycles + enable_cycles + download_cycles +
		button_cycles + filter_cycles + split_cycles + margin_cycles;

	logic                 clk_sys;
	logic                 reset;
	logic                 dl_wr;
	logic [7:0]           dl_index;
	logic [24:0]          dl_addr;
	logic [7:0]           dl_data;
	logic [15:0]          usb_joy_0;
	logic [15:0]          usb_joy_1;
	logic [31:0]          ll_buttons_0;
	logic [31:0]          ll_buttons_1;
	logic                 ce_6m;
	logic                 ce_4m;
	logic                 ce_1m79;
	arcade_pkg::variant_t game_variant;
	logic [7:0]           in0;
	logic [7:0]           in1;
	logic [7:0]           dipsw1;
	logic [7:0]           dipsw2;
	logic                 osd_button;

	int         seed = 81;
	// DIP bytes as last written by the loader
	logic [7:0] dip_copy [4];

	arcade_ctrl_top #(
		.DIV_6M   (div_6m),
		.DIV_4M   (div_4m),
		.DIV_1M79 (div_1m79)
	) uut (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_wr        (dl_wr),
		.dl_index     (dl_index),
		.dl_addr      (dl_addr),
		.dl_data      (dl_data),
		.usb_joy_0    (usb_joy_0),
		.usb_joy_1    (usb_joy_1),
		.ll_buttons_0 (ll_buttons_0),
		.ll_buttons_1 (ll_buttons_1),
		.ce_6m        (ce_6m),
		.ce_4m        (ce_4m),
		.ce_1m79      (ce_1m79),
		.game_variant (game_variant),
		.in0          (in0),
		.in1          (in1),
		.dipsw1       (dipsw1),
		.dipsw2       (dipsw2),
		.osd_button   (osd_button)
	);

	initial begin
		clk_sys = 1'b0;
		forever #(clk_period / 2) clk_sys = ~clk_sys;
	end

	// Watchdog
	initial begin
		#(clk_period * run_cycles);
		stop_run("watchdog expired before the tests finished");
	end

	// ====================
	// Helpers
	// ====================

	task automatic stop_run(input string why);
		$display("Regression failed");
		$fatal(1, why);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("ERR %0t %s got %0h expected %0h", $time, name, got, exp);
			stop_run("value mismatch");
		end
	endtask

	// Inputs change on the falling edge only
	task automatic tick(input int n);
		repeat (n) @(negedge clk_sys);
	endtask

	// One cycle loader strobe
	task automatic load_byte(input logic [7:0] index, input logic [24:0] addr,
		input logic [7:0] data);
		dl_index = index;
		dl_addr  = addr;
		dl_data  = data;
		dl_wr    = 1'b1;
		tick(1);
		dl_wr = 1'b0;
	endtask

	task automatic set_dip(input logic [1:0] slot, input logic [7:0] data);
		load_byte(arcade_pkg::dl_index_dip, {23'd0, slot}, data);
		dip_copy[slot] = data;
	endtask

	// Variant decode lands on the second edge after the write
	task automatic select_variant(input logic [7:0] code, input arcade_pkg::variant_t v);
		load_byte(arcade_pkg::dl_index_variant, 25'd0, code);
		tick(1);
		check("game_variant", 32'(game_variant), 32'(v));
	endtask

	function automatic logic ce_pick(input int sel);
		case (sel)
			0: return ce_6m;
			1: return ce_4m;
			default: return ce_1m79;
		endcase
	endfunction

	function automatic logic ponp_family(input arcade_pkg::variant_t v);
		return v == arcade_pkg::variant_ponp || v == arcade_pkg::variant_van ||
			v == arcade_pkg::variant_dshop;
	endfunction

	// Adapter word laid out as a pad word
	function automatic logic [15:0] adapter_pad(input logic [31:0] b);
		logic [15:0] p;
		p = 16'h0000;
		p[arcade_pkg::joy_right]  = b[arcade_pkg::ll_right];
		p[arcade_pkg::joy_left]   = b[arcade_pkg::ll_left];
		p[arcade_pkg::joy_down]   = b[arcade_pkg::ll_down];
		p[arcade_pkg::joy_up]     = b[arcade_pkg::ll_up];
		p[arcade_pkg::joy_fire]   = b[arcade_pkg::ll_fire];
		p[arcade_pkg::joy_start1] = b[arcade_pkg::ll_start1];
		p[arcade_pkg::joy_start2] = b[arcade_pkg::ll_start2];
		p[arcade_pkg::joy_coin]   = b[arcade_pkg::ll_coin];
		return p;
	endfunction

	// Player 1 pad in the upper half, player 2 in the lower
	function automatic logic [31:0] merged_pads(input arcade_pkg::variant_t v,
		input logic [15:0] u0, input logic [15:0] u1, input logic [31:0] l0,
		input logic [31:0] l1);
		logic [15:0] all;
		all = u0 | u1 | adapter_pad(l0) | adapter_pad(l1);
		if (v == arcade_pkg::variant_club || v == arcade_pkg::variant_jmpst)
			return {adapter_pad(l0), adapter_pad(l1)};
		return {all, all};
	endfunction

	function automatic logic [7:0] in0_value(input arcade_pkg::variant_t v,
		input logic [15:0] p1, input logic [15:0] p2, input logic [3:0] dirs,
		input logic [7:0] dip);
		logic [7:0] b;
		logic       fire;
		fire = p1[arcade_pkg::joy_fire];
		b[7] = (v == arcade_pkg::variant_eeek) && p2[arcade_pkg::joy_fire];
		b[6] = (v == arcade_pkg::variant_alib) && fire;
		b[5] = p1[arcade_pkg::joy_coin] || p2[arcade_pkg::joy_coin];
		if (v inside {arcade_pkg::variant_orig, arcade_pkg::variant_plus,
			arcade_pkg::variant_ms, arcade_pkg::variant_bird,
			arcade_pkg::variant_alib, arcade_pkg::variant_woodp})
			b[4] = p1[arcade_pkg::joy_cheat] || p2[arcade_pkg::joy_cheat];
		else
			b[4] = ponp_family(v) && fire;
		b[3:0] = {dirs[arcade_pkg::joy_down], dirs[arcade_pkg::joy_right],
			dirs[arcade_pkg::joy_left], dirs[arcade_pkg::joy_up]};
		// Ponp keeps the low five bits active high
		b = b ^ ((v == arcade_pkg::variant_ponp) ? 8'hE0 : 8'hFF);
		return b & dip;
	endfunction

	function automatic logic [7:0] in1_value(input arcade_pkg::variant_t v,
		input logic [15:0] p1, input logic [15:0] p2, input logic [3:0] dirs,
		input logic [7:0] dip);
		logic [7:0] b;
		logic       fire;
		logic       fire2;
		logic       gm;
		fire  = p1[arcade_pkg::joy_fire];
		fire2 = p2[arcade_pkg::joy_fire];
		gm    = v == arcade_pkg::variant_gork || v == arcade_pkg::variant_mrtnt;
		b[7] = gm && fire2;
		b[6] = p1[arcade_pkg::joy_start2] || p2[arcade_pkg::joy_start2] ||
			(v == arcade_pkg::variant_eeek && fire) || (v == arcade_pkg::variant_jmpst && fire2);
		b[5] = p1[arcade_pkg::joy_start1] || p2[arcade_pkg::joy_start1] ||
			(v == arcade_pkg::variant_jmpst && fire);
		b[4] = (gm && fire) || ((v == arcade_pkg::variant_alib || ponp_family(v)) && fire2);
		// Pmm has no player 2 stick, fire sits on right
		if (v == arcade_pkg::variant_pmm)
			b[3:0] = {1'b0, fire, 2'b00};
		else
			b[3:0] = {dirs[arcade_pkg::joy_down], dirs[arcade_pkg::joy_right],
				dirs[arcade_pkg::joy_left], dirs[arcade_pkg::joy_up]};
		b = b ^ ((v == arcade_pkg::variant_ponp) ? 8'h00 : 8'hFF);
		return b & dip;
	endfunction

	// Drive all pads, wait, then compare both game ports
	task automatic apply_pads(input arcade_pkg::variant_t v, input logic [15:0] u0,
		input logic [15:0] u1, input logic [31:0] l0, input logic [31:0] l1,
		input logic [3:0] dirs, input int settle);
		logic [31:0] pads;
		usb_joy_0    = u0;
		usb_joy_1    = u1;
		ll_buttons_0 = l0;
		ll_buttons_1 = l1;
		tick(settle);
		pads = merged_pads(v, u0, u1, l0, l1);
		check("in0", 32'(in0), 32'(in0_value(v, pads[31:16], pads[15:0], dirs, dip_copy[0])));
		check("in1", 32'(in1), 32'(in1_value(v, pads[31:16], pads[15:0], dirs, dip_copy[1])));
	endtask

	// ====================
	// Tests
	// ====================

	task automatic measure_period(input int sel, input string name, input int period);
		int waited;
		int gap;
		waited = 0;
		while (!ce_pick(sel) && waited < 4 * period) begin
			tick(1);
			waited++;
		end
		if (!ce_pick(sel))
			stop_run({name, " never pulsed"});
		// Three spacings between consecutive pulses
		for (int n = 0; n < 3; n++) begin
			gap = 0;
			do begin
				tick(1);
				gap++;
			end while (!ce_pick(sel) && gap < 2 * period);
			check(name, gap, period);
		end
	endtask

	task automatic enable_periods();
		measure_period(0, "ce_6m", div_6m);
		measure_period(1, "ce_4m", div_4m);
		measure_period(2, "ce_1m79", div_1m79);
	endtask

	task automatic download_capture();
		select_variant(8'd5, arcade_pkg::variant_ms);
		select_variant(8'd12, arcade_pkg::variant_van);
		set_dip(2'd2, 8'hA5);
		set_dip(2'd3, 8'h3C);
		tick(1);
		check("dipsw1", 32'(dipsw1), 32'(dip_copy[2]));
		check("dipsw2", 32'(dipsw2), 32'(dip_copy[3]));
		// Address bit 3 set, outside the DIP bank
		load_byte(arcade_pkg::dl_index_dip, 25'h00000A, 8'h00);
		load_byte(arcade_pkg::dl_index_dip, 25'h00000B, 8'h00);
		tick(2);
		check("dipsw1", 32'(dipsw1), 32'(dip_copy[2]));
		check("dipsw2", 32'(dipsw2), 32'(dip_copy[3]));
		select_variant(8'd16, arcade_pkg::variant_jmpst);
		tick(1);
		check("dipsw2", 32'(dipsw2), 32'h0000_00FF);
		select_variant(8'd3, arcade_pkg::variant_other);
	endtask

	// Buttons only, directions stay idle
	task automatic button_ports(input logic [7:0] code, input arcade_pkg::variant_t v);
		logic [15:0] u0;
		logic [15:0] u1;
		select_variant(code, v);
		for (int r = 0; r < 3; r++) begin
			set_dip(2'd0, 8'($random(seed)));
			set_dip(2'd1, 8'($random(seed)));
			u0 = 16'($random(seed)) & 16'h01F0;
			u1 = 16'($random(seed)) & 16'h01F0;
			apply_pads(v, u0, u1, 32'd0, 32'd0, 4'h0, 4);
		end
		apply_pads(v, 16'h0000, 16'h0000, 32'd0, 32'd0, 4'h0, 3);
	endtask

	task automatic direction_filter();
		logic [15:0] right;
		logic [15:0] up;
		right = 16'h0001 << arcade_pkg::joy_right;
		up    = 16'h0001 << arcade_pkg::joy_up;
		set_dip(2'd0, 8'hFF);
		set_dip(2'd1, 8'hFF);
		select_variant(8'd0, arcade_pkg::variant_orig);
		apply_pads(arcade_pkg::variant_orig, right, 16'h0000, 32'd0, 32'd0, right[3:0], 4);
		// Newest press wins
		apply_pads(arcade_pkg::variant_orig, right | up, 16'h0000, 32'd0, 32'd0, up[3:0], 4);
		apply_pads(arcade_pkg::variant_orig, right, 16'h0000, 32'd0, 32'd0, right[3:0], 4);
		apply_pads(arcade_pkg::variant_orig, 16'h0000, 16'h0000, 32'd0, 32'd0, 4'h0, 4);
		// Bird keeps diagonals
		select_variant(8'd4, arcade_pkg::variant_bird);
		apply_pads(arcade_pkg::variant_bird, right | up, 16'h0000, 32'd0, 32'd0,
			right[3:0] | up[3:0], 4);
		apply_pads(arcade_pkg::variant_bird, 16'h0000, 16'h0000, 32'd0, 32'd0, 4'h0, 4);
	endtask

	task automatic split_players();
		logic [15:0] u0;
		logic [15:0] u1;
		logic [31:0] fire_bit;
		logic [31:0] osd_combo;
		// USB noise that the split variants must ignore
		u0 = (16'h0001 << arcade_pkg::joy_coin) | (16'h0001 << arcade_pkg::joy_start2);
		u1 = 16'h0001 << arcade_pkg::joy_fire;
		fire_bit  = 32'h1 << arcade_pkg::ll_fire;
		osd_combo = (32'h1 << arcade_pkg::ll_down) | (32'h1 << arcade_pkg::ll_start1);
		select_variant(8'd2, arcade_pkg::variant_club);
		apply_pads(arcade_pkg::variant_club, u0, u1, 32'h1 << arcade_pkg::ll_start1, 32'd0,
			4'h0, 3);
		select_variant(8'd16, arcade_pkg::variant_jmpst);
		apply_pads(arcade_pkg::variant_jmpst, u0, u1, fire_bit, 32'd0, 4'h0, 3);
		apply_pads(arcade_pkg::variant_jmpst, u0, u1, 32'd0, fire_bit, 4'h0, 3);
		// OSD needs all three buttons on one adapter
		ll_buttons_1 = osd_combo;
		tick(1);
		check("osd_button", {31'd0, osd_button}, 32'd0);
		ll_buttons_1 = osd_combo | fire_bit;
		tick(1);
		check("osd_button", {31'd0, osd_button}, 32'd1);
		apply_pads(arcade_pkg::variant_jmpst, 16'h0000, 16'h0000, 32'd0, 32'd0, 4'h0, 3);
		check("osd_button", {31'd0, osd_button}, 32'd0);
	endtask

	// ====================
	// Main sequence
	// ====================

	initial begin
		reset        = 1'b1;
		dl_wr        = 1'b0;
		dl_index     = 8'd0;
		dl_addr      = 25'd0;
		dl_data      = 8'd0;
		usb_joy_0    = 16'h0000;
		usb_joy_1    = 16'h0000;
		ll_buttons_0 = 32'd0;
		ll_buttons_1 = 32'd0;
		for (int i = 0; i < 4; i++)
			dip_copy[i] = arcade_pkg::dip_reset_value;
		tick(reset_cycles);
		reset = 1'b0;

		enable_periods();
		download_capture();
		button_ports(8'd0, arcade_pkg::variant_orig);
		button_ports(8'd5, arcade_pkg::variant_ms);
		button_ports(8'd6, arcade_pkg::variant_gork);
		button_ports(8'd8, arcade_pkg::variant_woodp);
		button_ports(8'd9, arcade_pkg::variant_eeek);
		button_ports(8'd10, arcade_pkg::variant_alib);
		button_ports(8'd11, arcade_pkg::variant_ponp);
		button_ports(8'd12, arcade_pkg::variant_van);
		button_ports(8'd13, arcade_pkg::variant_pmm);
		direction_filter();
		split_players();

		$display("Regression passed");
		$finish;
	end

endmodule

// File: flist.f
design/arcade_pkg.sv
design/clock_enables.sv
design/rom_config_capture.sv
design/pad_merge.sv
design/one_dir_filter.sv
design/input_port_map.sv
design/arcade_ctrl_top.sv
test/arcade_ctrl_properties.sv
test/tb_arcade_ctrl.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_arcade_ctrl
FLIST     = flist.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
